// ==== Bender.yml ====
package:
  name: int_pipe

sources:
  - src/mips_pkg.sv
  - src/inst_decoder.sv
  - src/operand_bypass.sv
  - src/alu.sv
  - src/reg_file.sv
  - src/int_pipe_top.sv
  - target: simulation
    files:
      - dv/int_pipe_chk.sv
      - dv/int_pipe_tb.sv

// ==== dv/int_pipe_chk.sv ====
// Writeback port assertions for the integer pipeline.
module int_pipe_chk import mips_pkg::*; (
    input logic      clk,
    input logic      rst_n,
    input logic      inst_valid,
    input logic      wb_valid,
    input reg_addr_t wb_addr
);

    timeunit 1ns;
    timeprecision 1ps;

    int fail_count = 0;

    wb_addr_nonzero: assert property (
        @(posedge clk) disable iff (!rst_n) wb_valid |-> wb_addr != zero_reg
    ) else begin
        $error("writeback to register 0");
        fail_count++;
    end

    // quiet for two edges once reset drops.
    quiet_after_reset: assert property (
        @(posedge clk) $rose(rst_n) |-> !wb_valid ##1 !wb_valid
    ) else begin
        $error("writeback right after reset");
        fail_count++;
    end

    wb_follows_issue: assert property (
        @(posedge clk) disable iff (!rst_n) wb_valid |-> $past(inst_valid, 3)
    ) else begin
        $error("writeback without an instruction three edges earlier");
        fail_count++;
    end

endmodule

// ==== dv/int_pipe_tb.sv ====
// Testbench for the three-stage integer pipeline.
// directed tests against a register file model, checked at the writeback port.
module int_pipe_tb import mips_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int clk_period = 100;

    logic      clk;
    logic      rst_n;
    logic      inst_valid;
    word_t     inst;
    logic      wb_valid;
    reg_addr_t wb_addr;
    word_t     wb_data;

    word_t     model_regs [num_regs];
    wb_stage_t exp_q [$];   // one entry per slot, bubbles included.
    int        error_count = 0;
    int        check_count = 0;
    int        slot_count = 0;
    int        tests_run = 0;
    int        tests_failed = 0;
    int        test_start_errs = 0;

    int_pipe_top int_pipe_top_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .inst       (inst),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr),
        .wb_data    (wb_data)
    );

    bind int_pipe_top int_pipe_chk int_pipe_chk_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .inst_valid (inst_valid),
        .wb_valid   (wb_valid),
        .wb_addr    (wb_addr)
    );

    initial begin
        clk = 1'b0;
        forever #(clk_period / 2) clk = ~clk;
    end

    // deadline moves with every issued slot.
    initial begin
        while ($time <= longint'(slot_count + 50) * clk_period) begin
            @(posedge clk);
        end
        $display("timeout: run still going after %0d instruction slots", slot_count);
        $display("=== FAIL ===");
        $finish;
    end

    function automatic int total_errors();
        return error_count + int_pipe_top_i.int_pipe_chk_i.fail_count;
    endfunction

    task automatic check_word(input word_t got, input word_t want, input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %h, expected %h", $time, what, got, want);
        end
    endtask

    task automatic check_addr(input reg_addr_t got, input reg_addr_t want, input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %0d, expected %0d", $time, what, got, want);
        end
    endtask

    task automatic check_bit(input logic got, input logic want, input string what);
        check_count++;
        if (got !== want) begin
            error_count++;
            $display("CHECK FAILED at %0t: %s is %b, expected %b", $time, what, got, want);
        end
    endtask

    function automatic word_t enc_r(funct_t fn, reg_addr_t rs, reg_addr_t rt, reg_addr_t rd,
                                    shamt_t sa = '0);
        return {op_special, rs, rt, rd, sa, fn};
    endfunction

    function automatic word_t enc_i(opcode_t op, reg_addr_t rs, reg_addr_t rt, imm16_t imm);
        return {op, rs, rt, imm};
    endfunction

    // expected writeback of one instruction, from the model registers.
    function automatic wb_stage_t predict(word_t ins);
        opcode_t   op;
        funct_t    fn;
        reg_addr_t rs;
        reg_addr_t rt;
        shamt_t    sa;
        word_t     a;
        word_t     b;
        word_t     simm;
        word_t     zimm;
        wb_stage_t r;
        op = ins[31:26];
        rs = ins[25:21];
        rt = ins[20:16];
        sa = ins[10:6];
        fn = ins[5:0];
        a = model_regs[rs];
        b = model_regs[rt];
        simm = {{16{ins[15]}}, ins[15:0]};
        zimm = {16'h0000, ins[15:0]};
        r.wreg = 1'b1;
        r.wr_addr = ins[15:11];
        r.data = '0;
        if (op == op_special) begin
            if (fn == fn_sll || fn == fn_srl || fn == fn_sra) begin
                r.wreg = (rs == '0);
                case (fn)
                    fn_sll:  r.data = b << sa;
                    fn_srl:  r.data = b >> sa;
                    default: r.data = $signed(b) >>> sa;
                endcase
            end else begin
                r.wreg = (sa == '0);
                case (fn)
                    fn_sllv:         r.data = b << a[4:0];
                    fn_srlv:         r.data = b >> a[4:0];
                    fn_srav:         r.data = $signed(b) >>> a[4:0];
                    fn_add, fn_addu: r.data = a + b;
                    fn_sub, fn_subu: r.data = a - b;
                    fn_and:          r.data = a & b;
                    fn_or:           r.data = a | b;
                    fn_xor:          r.data = a ^ b;
                    fn_nor:          r.data = ~(a | b);
                    fn_slt:          r.data = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
                    fn_sltu:         r.data = (a < b) ? 32'd1 : 32'd0;
                    fn_movz: begin
                        r.data = a;
                        r.wreg = r.wreg && (b == '0);
                    end
                    fn_movn: begin
                        r.data = a;
                        r.wreg = r.wreg && (b != '0);
                    end
                    default: r.wreg = 1'b0;
                endcase
            end
        end else begin
            r.wr_addr = rt;
            case (op)
                op_addi, op_addiu: r.data = a + simm;
                op_slti:  r.data = ($signed(a) < $signed(simm)) ? 32'd1 : 32'd0;
                op_sltiu: r.data = (a < simm) ? 32'd1 : 32'd0;
                op_andi:  r.data = a & zimm;
                op_ori:   r.data = a | zimm;
                op_xori:  r.data = a ^ zimm;
                op_lui: begin
                    r.wreg = (rs == '0);
                    r.data = {ins[15:0], 16'h0000};
                end
                default: r.wreg = 1'b0;
            endcase
        end
        if (r.wr_addr == '0) begin
            r.wreg = 1'b0;
        end
        return r;
    endfunction

    // one slot per falling edge; the result of slot n shows three falling edges later.
    task automatic issue(input logic v, input word_t ins);
        wb_stage_t want;
        wb_stage_t due;
        @(negedge clk);
        if (exp_q.size() >= 3) begin
            due = exp_q.pop_front();
            check_bit(wb_valid, due.wreg, "wb_valid");
            if (due.wreg) begin
                check_addr(wb_addr, due.wr_addr, "wb_addr");
                check_word(wb_data, due.data, "wb_data");
            end
        end
        want = '0;
        if (v) begin
            want = predict(ins);
            if (want.wreg) begin
                model_regs[want.wr_addr] = want.data;
            end
        end
        inst_valid = v;
        inst = ins;
        exp_q.push_back(want);
        slot_count++;
    endtask

    task automatic drain();
        repeat (3) issue(1'b0, '0);
    endtask

    task automatic begin_test();
        test_start_errs = total_errors();
    endtask

    task automatic end_test(input string name);
        int errs;
        errs = total_errors() - test_start_errs;
        tests_run++;
        if (errs == 0) begin
            $display("test %s: passed", name);
        end else begin
            tests_failed++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic test_reset();
        begin_test();
        for (int i = 0; i < num_regs; i++) begin
            model_regs[i] = '0;
        end
        repeat (5) begin
            @(negedge clk);
            check_bit(wb_valid, 1'b0, "wb_valid in reset");
            slot_count++;
        end
        rst_n = 1'b1;
        repeat (3) issue(1'b0, '0);
        issue(1'b1, enc_r(fn_addu, 5'd3, 5'd4, 5'd5));   // reads before any write.
        issue(1'b1, enc_r(fn_or, 5'd7, 5'd8, 5'd6));
        issue(1'b1, enc_i(op_addiu, 5'd9, 5'd10, 16'h0001));
        drain();
        end_test("reset");
    endtask

    task automatic test_reg_forms();
        funct_t fns [13] = '{fn_sllv, fn_srlv, fn_srav, fn_add, fn_addu, fn_sub, fn_subu,
                             fn_and, fn_or, fn_xor, fn_nor, fn_slt, fn_sltu};
        word_t  v;
        begin_test();
        for (int r = 1; r <= 8; r++) begin
            v = $urandom;
            issue(1'b1, enc_i(op_ori, 5'd0, reg_addr_t'(r), v[15:0]));
            if (r > 4) begin
                issue(1'b1, enc_i(op_lui, 5'd0, 5'd31, v[31:16]));
                issue(1'b1, enc_r(fn_or, reg_addr_t'(r), 5'd31, reg_addr_t'(r)));
            end
        end
        issue(1'b1, enc_i(op_lui, 5'd0, 5'd16, 16'h7fff));
        issue(1'b1, enc_i(op_ori, 5'd16, 5'd16, 16'hffff));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd17, 16'h0001));
        issue(1'b1, enc_r(fn_add, 5'd16, 5'd17, 5'd18));   // wraps to 0x80000000.
        issue(1'b1, enc_r(fn_sub, 5'd0, 5'd17, 5'd19));
        issue(1'b1, enc_r(fn_subu, 5'd17, 5'd16, 5'd20));
        issue(1'b1, enc_r(fn_slt, 5'd19, 5'd17, 5'd21));
        issue(1'b1, enc_r(fn_sltu, 5'd19, 5'd17, 5'd22));
        for (int i = 0; i < 24; i++) begin
            issue(1'b1, enc_r(fns[$urandom % 13], reg_addr_t'(1 + $urandom % 15),
                              reg_addr_t'(1 + $urandom % 15), reg_addr_t'(9 + $urandom % 7)));
        end
        drain();
        end_test("register forms");
    endtask

    task automatic test_imm_forms();
        begin_test();
        issue(1'b1, enc_i(op_addi, 5'd0, 5'd1, 16'hfff0));
        issue(1'b1, enc_i(op_slti, 5'd1, 5'd2, 16'hffff));
        issue(1'b1, enc_i(op_slti, 5'd1, 5'd3, 16'h8000));
        issue(1'b1, enc_i(op_andi, 5'd1, 5'd4, 16'h8f0f));
        issue(1'b1, enc_i(op_ori, 5'd0, 5'd5, 16'h8000));
        issue(1'b1, enc_i(op_xori, 5'd1, 5'd6, 16'hffff));
        issue(1'b1, enc_i(op_lui, 5'd0, 5'd7, 16'h8001));
        issue(1'b1, enc_i(op_sltiu, 5'd0, 5'd8, 16'hffff));
        issue(1'b1, enc_i(op_sltiu, 5'd1, 5'd9, 16'hffff));
        issue(1'b1, enc_i(op_sltiu, 5'd7, 5'd10, 16'h0001));
        issue(1'b1, enc_i(op_addiu, 5'd7, 5'd11, 16'h8000));
        issue(1'b1, enc_r(fn_sll, 5'd0, 5'd7, 5'd12, 5'd4));
        issue(1'b1, enc_r(fn_srl, 5'd0, 5'd7, 5'd13, 5'd31));
        issue(1'b1, enc_r(fn_sra, 5'd0, 5'd7, 5'd14, 5'd4));
        issue(1'b1, enc_r(fn_sra, 5'd0, 5'd1, 5'd15, 5'd0));
        drain();
        end_test("immediate forms");
    endtask

    task automatic test_bypass();
        begin_test();
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd3, 16'd5));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd3, 16'd9));
        issue(1'b1, enc_r(fn_addu, 5'd3, 5'd3, 5'd4));   // EX beats writeback.
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd5, 16'd7));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd6, 16'd1));
        issue(1'b1, enc_r(fn_addu, 5'd5, 5'd0, 5'd7));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd8, 16'd11));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd20, 16'd2));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd21, 16'd3));
        issue(1'b1, enc_r(fn_addu, 5'd8, 5'd0, 5'd9));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd10, 16'd21));
        issue(1'b0, enc_i(op_addiu, 5'd0, 5'd10, 16'd99));   // bubble carrying a live word.
        issue(1'b1, enc_r(fn_addu, 5'd10, 5'd10, 5'd11));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd12, 16'd40));
        issue(1'b0, enc_i(op_addiu, 5'd0, 5'd12, 16'd55));
        issue(1'b0, enc_r(fn_addu, 5'd12, 5'd12, 5'd11));
        issue(1'b1, enc_r(fn_subu, 5'd12, 5'd11, 5'd13));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd14, 16'd1));
        issue(1'b0, enc_i(op_addiu, 5'd0, 5'd14, 16'd66));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd14, 16'd2));
        issue(1'b1, enc_r(fn_addu, 5'd14, 5'd14, 5'd15));
        drain();
        end_test("bypass");
    endtask

    task automatic test_suppressed();
        begin_test();
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd1, 16'h0000));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd2, 16'h0033));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd3, 16'h0044));
        issue(1'b1, enc_r(fn_movz, 5'd2, 5'd1, 5'd4));
        issue(1'b1, enc_r(fn_movz, 5'd2, 5'd3, 5'd5));
        issue(1'b1, enc_r(fn_movn, 5'd2, 5'd3, 5'd6));
        issue(1'b1, enc_r(fn_movn, 5'd2, 5'd1, 5'd7));
        issue(1'b1, enc_i(op_addiu, 5'd0, 5'd0, 16'h0055));
        issue(1'b1, enc_r(fn_addu, 5'd2, 5'd3, 5'd0));
        issue(1'b1, enc_r(fn_addu, 5'd0, 5'd0, 5'd8));
        issue(1'b1, {6'h3f, 5'd2, 5'd9, 16'h1234});
        issue(1'b1, enc_r(fn_addu, 5'd2, 5'd3, 5'd9, 5'd3));
        issue(1'b1, enc_r(6'h01, 5'd2, 5'd3, 5'd9));
        issue(1'b1, enc_i(op_lui, 5'd2, 5'd9, 16'hbeef));
        issue(1'b1, enc_r(fn_addu, 5'd9, 5'd0, 5'd10));
        drain();
        end_test("suppressed writes");
    endtask

    initial begin
        void'($urandom(2680));
        rst_n = 1'b0;
        inst_valid = 1'b0;
        inst = '0;
        test_reset();
        test_reg_forms();
        test_imm_forms();
        test_bypass();
        test_suppressed();
        $display("tests %0d, failed %0d, checks %0d, errors %0d",
                 tests_run, tests_failed, check_count, total_errors());
        if (total_errors() == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
src/mips_pkg.sv
src/inst_decoder.sv
src/operand_bypass.sv
src/alu.sv
src/reg_file.sv
src/int_pipe_top.sv
dv/int_pipe_chk.sv
dv/int_pipe_tb.sv

// ==== src/alu.sv ====
// Integer ALU for the EX stage.
// also resolves the MOVZ/MOVN write condition.
module alu import mips_pkg::*; (
    input  ex_stage_t ex,
    output wb_stage_t res,
    output fwd_t      ex_fwd
);

    shamt_t shamt;
    word_t  result;
    logic   cond_ok;

    assign shamt = ex.opr1[4:0];   // variable and sa shifts alike.

    always_comb begin
        result  = '0;
        cond_ok = 1'b1;
        case (ex.alu_op)
            alu_add:  result = ex.opr1 + ex.opr2;
            alu_sub:  result = ex.opr1 - ex.opr2;
            alu_and:  result = ex.opr1 & ex.opr2;
            alu_or:   result = ex.opr1 | ex.opr2;
            alu_xor:  result = ex.opr1 ^ ex.opr2;
            alu_nor:  result = ~(ex.opr1 | ex.opr2);
            alu_slt:  result = word_t'($signed(ex.opr1) < $signed(ex.opr2));
            alu_sltu: result = word_t'(ex.opr1 < ex.opr2);
            alu_sll:  result = ex.opr2 << shamt;
            alu_srl:  result = ex.opr2 >> shamt;
            alu_sra:  result = word_t'($signed(ex.opr2) >>> shamt);
            alu_movz: begin
                result  = ex.opr1;
                cond_ok = (ex.opr2 == '0);
            end
            alu_movn: begin
                result  = ex.opr1;
                cond_ok = (ex.opr2 != '0);
            end
            default: begin
                result  = '0;
                cond_ok = 1'b0;
            end
        endcase
    end

    assign res.wreg    = ex.valid && ex.wreg && cond_ok;
    assign res.wr_addr = ex.wr_addr;
    assign res.data    = result;

    // same result goes back to decode.
    assign ex_fwd.wreg    = res.wreg;
    assign ex_fwd.wr_addr = res.wr_addr;
    assign ex_fwd.data    = res.data;

endmodule

// ==== src/inst_decoder.sv ====
// Instruction decoder for the integer pipeline.
// maps one MIPS32 word to ALU op, reads, destination and extended immediate.
module inst_decoder import mips_pkg::*; (
    input  word_t inst,
    output dec_t  dec
);

    opcode_t   opcode;
    reg_addr_t rs;
    reg_addr_t rt;
    reg_addr_t rd;
    shamt_t    sa;
    funct_t    funct;
    imm16_t    imm;

    word_t   sign_ext;
    word_t   zero_ext;
    word_t   lui_ext;
    alu_op_e sp_op;
    logic    sa_form;
    alu_op_e imm_op;
    word_t   imm_val;

    assign opcode = inst[31:26];
    assign rs     = inst[25:21];
    assign rt     = inst[20:16];
    assign rd     = inst[15:11];
    assign sa     = inst[10:6];
    assign funct  = inst[5:0];
    assign imm    = inst[15:0];

    assign sign_ext = {{16{imm[15]}}, imm};
    assign zero_ext = {16'h0000, imm};
    assign lui_ext  = {imm, 16'h0000};

    // SLL/SRL/SRA take the shift amount from sa.
    assign sa_form = (funct == fn_sll) || (funct == fn_srl) || (funct == fn_sra);

    always_comb begin
        case (funct)
            fn_sll, fn_sllv:  sp_op = alu_sll;
            fn_srl, fn_srlv:  sp_op = alu_srl;
            fn_sra, fn_srav:  sp_op = alu_sra;
            fn_movz:          sp_op = alu_movz;
            fn_movn:          sp_op = alu_movn;
            fn_add, fn_addu:  sp_op = alu_add;   // no overflow trap.
            fn_sub, fn_subu:  sp_op = alu_sub;
            fn_and:           sp_op = alu_and;
            fn_or:            sp_op = alu_or;
            fn_xor:           sp_op = alu_xor;
            fn_nor:           sp_op = alu_nor;
            fn_slt:           sp_op = alu_slt;
            fn_sltu:          sp_op = alu_sltu;
            default:          sp_op = alu_nop;
        endcase
    end

    always_comb begin
        imm_op  = alu_nop;
        imm_val = sign_ext;
        case (opcode)
            op_addi, op_addiu: imm_op = alu_add;
            op_slti:           imm_op = alu_slt;
            op_sltiu:          imm_op = alu_sltu;  // unsigned compare, sign-extended imm.
            op_andi: begin
                imm_op  = alu_and;
                imm_val = zero_ext;
            end
            op_ori: begin
                imm_op  = alu_or;
                imm_val = zero_ext;
            end
            op_xori: begin
                imm_op  = alu_xor;
                imm_val = zero_ext;
            end
            op_lui: begin
                if (rs == '0) begin
                    imm_op  = alu_or;
                    imm_val = lui_ext;
                end
            end
            default: imm_op = alu_nop;
        endcase
    end

    always_comb begin
        dec         = '0;
        dec.r1_addr = rs;
        dec.r2_addr = rt;
        dec.wr_addr = rd;
        case (opcode)
            op_special: begin
                if (sa_form) begin
                    if (rs == '0) begin
                        dec.alu_op  = sp_op;
                        dec.r2_read = 1'b1;
                        dec.wreg    = 1'b1;
                        dec.ext_imm = word_t'(sa);
                    end
                end else if (sa == '0 && sp_op != alu_nop) begin
                    dec.alu_op  = sp_op;
                    dec.r1_read = 1'b1;
                    dec.r2_read = 1'b1;
                    dec.wreg    = 1'b1;
                end
            end
            default: begin
                if (imm_op != alu_nop) begin
                    dec.alu_op  = imm_op;
                    dec.r1_read = 1'b1;
                    dec.wreg    = 1'b1;
                    dec.wr_addr = rt;
                    dec.ext_imm = imm_val;
                end
            end
        endcase
        // register 0 never takes a write.
        if (dec.wr_addr == zero_reg) begin
            dec.wreg = 1'b0;
        end
    end

endmodule

// ==== src/int_pipe_top.sv ====
// Three-stage integer pipeline, ID/EX/WB.
// one instruction per valid cycle, full operand bypass, no stalls.
module int_pipe_top import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      inst_valid,
    input  word_t     inst,
    output logic      wb_valid,
    output reg_addr_t wb_addr,
    output word_t     wb_data
);

    logic      id_valid;
    word_t     id_inst;
    dec_t      dec;
    word_t     r1_data;
    word_t     r2_data;
    word_t     opr1;
    word_t     opr2;
    fwd_t      ex_fwd;
    fwd_t      wb_fwd;
    ex_stage_t ex_q;
    wb_stage_t ex_res;
    wb_stage_t wb_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            id_valid <= 1'b0;
            id_inst  <= '0;
        end else begin
            id_valid <= inst_valid;
            id_inst  <= inst;
        end
    end

    inst_decoder inst_decoder_i (
        .inst (id_inst),
        .dec  (dec)
    );

    reg_file reg_file_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .r1_addr (dec.r1_addr),
        .r2_addr (dec.r2_addr),
        .r1_data (r1_data),
        .r2_data (r2_data),
        .wr      (wb_q)
    );

    assign wb_fwd.wreg    = wb_q.wreg;
    assign wb_fwd.wr_addr = wb_q.wr_addr;
    assign wb_fwd.data    = wb_q.data;

    operand_bypass operand_bypass_i (
        .dec     (dec),
        .r1_data (r1_data),
        .r2_data (r2_data),
        .ex_fwd  (ex_fwd),
        .wb_fwd  (wb_fwd),
        .opr1    (opr1),
        .opr2    (opr2)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ex_q <= '0;
        end else begin
            ex_q.valid   <= id_valid;
            ex_q.alu_op  <= dec.alu_op;
            ex_q.wreg    <= dec.wreg && id_valid;   // bubbles never write.
            ex_q.wr_addr <= dec.wr_addr;
            ex_q.opr1    <= opr1;
            ex_q.opr2    <= opr2;
        end
    end

    alu alu_i (
        .ex     (ex_q),
        .res    (ex_res),
        .ex_fwd (ex_fwd)
    );

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_q <= '0;
        end else begin
            wb_q <= ex_res;
        end
    end

    assign wb_valid = wb_q.wreg;
    assign wb_addr  = wb_q.wr_addr;
    assign wb_data  = wb_q.data;

endmodule

// ==== src/mips_pkg.sv ====
// MIPS32 integer pipeline shared definitions.
// field widths, instruction encodings, ALU ops and stage records.
package mips_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [4:0]  shamt_t;
    typedef logic [5:0]  opcode_t;
    typedef logic [5:0]  funct_t;
    typedef logic [15:0] imm16_t;

    localparam int        num_regs = 32;
    localparam reg_addr_t zero_reg = 5'd0;

    // primary opcodes.
    localparam opcode_t op_special = 6'h00;
    localparam opcode_t op_addi    = 6'h08;
    localparam opcode_t op_addiu   = 6'h09;
    localparam opcode_t op_slti    = 6'h0a;
    localparam opcode_t op_sltiu   = 6'h0b;
    localparam opcode_t op_andi    = 6'h0c;
    localparam opcode_t op_ori     = 6'h0d;
    localparam opcode_t op_xori    = 6'h0e;
    localparam opcode_t op_lui     = 6'h0f;

    // SPECIAL funct codes.
    localparam funct_t fn_sll  = 6'h00;
    localparam funct_t fn_srl  = 6'h02;
    localparam funct_t fn_sra  = 6'h03;
    localparam funct_t fn_sllv = 6'h04;
    localparam funct_t fn_srlv = 6'h06;
    localparam funct_t fn_srav = 6'h07;
    localparam funct_t fn_movz = 6'h0a;
    localparam funct_t fn_movn = 6'h0b;
    localparam funct_t fn_add  = 6'h20;
    localparam funct_t fn_addu = 6'h21;
    localparam funct_t fn_sub  = 6'h22;
    localparam funct_t fn_subu = 6'h23;
    localparam funct_t fn_and  = 6'h24;
    localparam funct_t fn_or   = 6'h25;
    localparam funct_t fn_xor  = 6'h26;
    localparam funct_t fn_nor  = 6'h27;
    localparam funct_t fn_slt  = 6'h2a;
    localparam funct_t fn_sltu = 6'h2b;

    typedef enum logic [3:0] {
        alu_nop, alu_add, alu_sub, alu_and, alu_or, alu_xor, alu_nor,
        alu_slt, alu_sltu, alu_sll, alu_srl, alu_sra, alu_movz, alu_movn
    } alu_op_e;

    typedef struct packed {
        alu_op_e   alu_op;
        logic      r1_read;
        reg_addr_t r1_addr;
        logic      r2_read;
        reg_addr_t r2_addr;
        logic      wreg;
        reg_addr_t wr_addr;
        word_t     ext_imm;   // immediate or sa, used by an unread operand.
    } dec_t;

    typedef struct packed {
        logic      valid;
        alu_op_e   alu_op;
        logic      wreg;
        reg_addr_t wr_addr;
        word_t     opr1;
        word_t     opr2;
    } ex_stage_t;

    typedef struct packed {
        logic      wreg;
        reg_addr_t wr_addr;
        word_t     data;
    } wb_stage_t;

    // one bypass source.
    typedef struct packed {
        logic      wreg;
        reg_addr_t wr_addr;
        word_t     data;
    } fwd_t;

endpackage

// ==== src/operand_bypass.sv ====
// Operand bypass for the decode stage.
// picks each source from EX result, writeback, register file or immediate.
module operand_bypass import mips_pkg::*; (
    input  dec_t  dec,
    input  word_t r1_data,
    input  word_t r2_data,
    input  fwd_t  ex_fwd,
    input  fwd_t  wb_fwd,
    output word_t opr1,
    output word_t opr2
);

    logic ex_r1_hit;
    logic ex_r2_hit;
    logic wb_r1_hit;
    logic wb_r2_hit;

    assign ex_r1_hit = ex_fwd.wreg && (ex_fwd.wr_addr == dec.r1_addr);
    assign ex_r2_hit = ex_fwd.wreg && (ex_fwd.wr_addr == dec.r2_addr);
    assign wb_r1_hit = wb_fwd.wreg && (wb_fwd.wr_addr == dec.r1_addr);
    assign wb_r2_hit = wb_fwd.wreg && (wb_fwd.wr_addr == dec.r2_addr);

    // newer EX result wins over writeback.
    always_comb begin
        if (!dec.r1_read) begin
            opr1 = dec.ext_imm;
        end else if (ex_r1_hit) begin
            opr1 = ex_fwd.data;
        end else if (wb_r1_hit) begin
            opr1 = wb_fwd.data;
        end else begin
            opr1 = r1_data;
        end
    end

    always_comb begin
        if (!dec.r2_read) begin
            opr2 = dec.ext_imm;
        end else if (ex_r2_hit) begin
            opr2 = ex_fwd.data;
        end else if (wb_r2_hit) begin
            opr2 = wb_fwd.data;
        end else begin
            opr2 = r2_data;
        end
    end

endmodule

// ==== src/reg_file.sv ====
// General purpose register file, 2 read ports and 1 write port.
module reg_file import mips_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  reg_addr_t r1_addr,
    input  reg_addr_t r2_addr,
    output word_t     r1_data,
    output word_t     r2_data,
    input  wb_stage_t wr
);

    // register 0 has no storage.
    word_t regs [1:num_regs-1];

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 1; i < num_regs; i++) begin
                regs[i] <= '0;
            end
        end else if (wr.wreg && wr.wr_addr != zero_reg) begin
            regs[wr.wr_addr] <= wr.data;
        end
    end

    // reads see the old value during a write.
    always_comb begin
        if (r1_addr == zero_reg) begin
            r1_data = '0;
        end else begin
            r1_data = regs[r1_addr];
        end
    end

    always_comb begin
        if (r2_addr == zero_reg) begin
            r2_data = '0;
        end else begin
            r2_data = regs[r2_addr];
        end
    end

endmodule
